//--- Makefile
VERILATOR = verilator
TOP       = tb_serial_alu
FILELIST  = sources.f
BUILD_DIR = obj_dir
VFLAGS    = --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- sources.f
+incdir+testbench
src/alu_pkg.sv
src/regmap_pkg.sv
src/nibble_alu.sv
src/nibble_counter.sv
src/nibble_loop.sv
src/axil_alu_regs.sv
src/serial_alu_top.sv
testbench/tb_serial_alu.sv

//--- src/alu_pkg.sv
// nibble ALU types; commands are 3 bits wide and code 7 is unused, the word is fixed at 8 nibbles
`default_nettype none

package alu_pkg;

    // word geometry
    localparam int NIBBLES = 8;
    localparam int IDX_W   = 3;

    // command codes as written to the CMD register
    typedef enum logic [2:0] {
        CMD_ADD   = 3'd0,
        CMD_SUB   = 3'd1,
        CMD_AND   = 3'd2,
        CMD_OR    = 3'd3,
        CMD_XOR   = 3'd4,
        CMD_RSHFT = 3'd5,
        CMD_INC   = 3'd6
    } alu_cmd_t;

    // operands of one nibble step, the command travels beside it
    typedef struct packed {
        logic [3:0] d1;
        logic [3:0] d2;
        logic       carry_in;
    } alu_args_t;

    // result of one nibble step
    typedef struct packed {
        logic [3:0] res;
        logic       carry_out;
    } alu_ret_t;

endpackage

`default_nettype wire

//--- src/axil_alu_regs.sv
// AXI4-Lite slave, one write and one read outstanding; addresses must match an offset exactly
`default_nettype none

module axil_alu_regs (
    input  logic                  clk,
    input  logic                  arst_n,
    input  regmap_pkg::axil_req_t bus_req,
    output regmap_pkg::axil_rsp_t bus_rsp,
    input  logic                  busy,
    input  logic                  carry,
    input  logic [31:0]           result,
    output logic                  start,
    output alu_pkg::alu_cmd_t     cmd,
    output logic [31:0]           word1,
    output logic [31:0]           word2
);
    import alu_pkg::*;
    import regmap_pkg::*;

    logic        awready_q;
    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic        arready_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic [1:0]  rresp_q;
    logic        start_q;
    alu_cmd_t    cmd_q;
    logic [31:0] word1_q;
    logic [31:0] word2_q;
    logic        aw_go;
    logic        ar_go;
    logic        loop_taken;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;

    function automatic logic [31:0] merge_strb(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [3:0]  strb
    );
        logic [31:0] merged;
        merged = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // ready pulses once both address and data are present and no response is pending
    assign aw_go = bus_req.awvalid && bus_req.wvalid && !awready_q && !bvalid_q;
    assign ar_go = bus_req.arvalid && !arready_q && !rvalid_q;

    // a command already launched counts as busy until the loop reports it
    assign loop_taken = busy || start_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
            bresp_q   <= RESP_OKAY;
            start_q   <= 1'b0;
            cmd_q     <= CMD_ADD;
            word1_q   <= '0;
            word2_q   <= '0;
        end else begin
            awready_q <= aw_go;
            start_q   <= 1'b0;
            if (bvalid_q && bus_req.bready) begin
                bvalid_q <= 1'b0;
            end
            // handshake cycle, valids are still held
            if (awready_q) begin
                bvalid_q <= 1'b1;
                bresp_q  <= RESP_OKAY;
                case (bus_req.awaddr)
                    ADDR_WORD1: begin
                        word1_q <= merge_strb(word1_q, bus_req.wdata, bus_req.wstrb);
                    end
                    ADDR_WORD2: begin
                        word2_q <= merge_strb(word2_q, bus_req.wdata, bus_req.wstrb);
                    end
                    ADDR_CMD: begin
                        if (loop_taken) begin
                            bresp_q <= RESP_SLVERR;
                        end else begin
                            cmd_q   <= alu_cmd_t'(bus_req.wdata[2:0]);
                            start_q <= 1'b1;
                        end
                    end
                    default: begin
                        bresp_q <= RESP_SLVERR;
                    end
                endcase
            end
        end
    end

    // read decode, unknown offsets give zero data
    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (bus_req.araddr)
            ADDR_WORD1:  rd_data = word1_q;
            ADDR_WORD2:  rd_data = word2_q;
            ADDR_CMD:    rd_data = {29'd0, cmd_q};
            ADDR_STATUS: rd_data = {30'd0, carry, busy};
            ADDR_RESULT: rd_data = result;
            default:     rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            rdata_q   <= '0;
            rresp_q   <= RESP_OKAY;
        end else begin
            arready_q <= ar_go;
            if (rvalid_q && bus_req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (arready_q) begin
                rvalid_q <= 1'b1;
                rdata_q  <= rd_data;
                rresp_q  <= rd_resp;
            end
        end
    end

    assign bus_rsp.awready = awready_q;
    assign bus_rsp.wready  = awready_q;
    assign bus_rsp.bvalid  = bvalid_q;
    assign bus_rsp.bresp   = bresp_q;
    assign bus_rsp.arready = arready_q;
    assign bus_rsp.rvalid  = rvalid_q;
    assign bus_rsp.rdata   = rdata_q;
    assign bus_rsp.rresp   = rresp_q;

    assign start = start_q;
    assign cmd   = cmd_q;
    assign word1 = word1_q;
    assign word2 = word2_q;

endmodule

`default_nettype wire

//--- src/nibble_alu.sv
// purely combinational one-nibble ALU; an unused command code passes d1 and the carry through
`default_nettype none

module nibble_alu (
    input  alu_pkg::alu_args_t args,
    input  alu_pkg::alu_cmd_t  cmd,
    output alu_pkg::alu_ret_t  ret
);
    import alu_pkg::*;

    logic [3:0] addend;
    logic [4:0] sum;

    // subtraction is addition of the inverted operand with carry in set
    assign addend = (cmd == CMD_SUB) ? ~args.d2 : args.d2;
    assign sum    = {1'b0, args.d1} + {1'b0, addend} + {4'd0, args.carry_in};

    always_comb begin
        ret.res       = args.d1;
        ret.carry_out = args.carry_in;
        case (cmd)
            CMD_ADD, CMD_SUB, CMD_INC: begin
                ret.res       = sum[3:0];
                ret.carry_out = sum[4];
            end
            CMD_AND: begin
                ret.res = args.d1 & args.d2;
            end
            CMD_OR: begin
                ret.res = args.d1 | args.d2;
            end
            CMD_XOR: begin
                ret.res = args.d1 ^ args.d2;
            end
            CMD_RSHFT: begin
                // bit from the higher nibble enters at the top
                ret.res       = {args.carry_in, args.d2[3:1]};
                ret.carry_out = args.d2[0];
            end
            default: begin
                ret.res       = args.d1;
                ret.carry_out = args.carry_in;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/nibble_counter.sv
// nibble index counter; load wins over step, and reverse must be stable while stepping
`default_nettype none

module nibble_counter (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      load,
    input  logic                      step,
    input  logic                      reverse,
    output logic                      last,
    output logic [alu_pkg::IDX_W-1:0] idx
);
    import alu_pkg::*;

    localparam logic [IDX_W-1:0] IDX_TOP = IDX_W'(NIBBLES - 1);

    logic [IDX_W-1:0] idx_first;
    logic [IDX_W-1:0] idx_final;

    // reverse walks from the top nibble down to nibble 0
    assign idx_first = reverse ? IDX_TOP : '0;
    assign idx_final = reverse ? '0 : IDX_TOP;
    assign last      = (idx == idx_final);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx <= '0;
        end else if (load) begin
            idx <= idx_first;
        end else if (step) begin
            if (reverse) begin
                idx <= idx - 1'b1;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/nibble_loop.sv
// runs the nibble ALU over a 32-bit word, one nibble per cycle; start is ignored while busy
`default_nettype none

module nibble_loop (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              start,
    input  alu_pkg::alu_cmd_t cmd,
    input  logic [31:0]       word1,
    input  logic [31:0]       word2,
    output logic              busy,
    output logic              carry,
    output logic [31:0]       result
);
    import alu_pkg::*;

    alu_cmd_t         cmd_q;
    logic             busy_q;
    logic             carry_q;
    logic [31:0]      result_q;
    logic             launch;
    logic             reverse;
    logic             last;
    logic             done;
    logic [IDX_W-1:0] idx;
    logic [IDX_W+1:0] nib_base;
    logic [3:0]       d2_nib;
    alu_args_t        args;
    alu_ret_t         ret;

    assign launch = start && !busy_q;

    // direction follows the incoming command at launch, the held one afterwards
    assign reverse = launch ? (cmd == CMD_RSHFT) : (cmd_q == CMD_RSHFT);

    nibble_counter u_counter (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (launch),
        .step    (busy_q && !done),
        .reverse (reverse),
        .last    (last),
        .idx     (idx)
    );

    // nibble select, bit offset of the current nibble
    assign nib_base = {idx, 2'b00};

    // INC only adds the low nibble of word2
    assign d2_nib = (cmd_q == CMD_INC && idx != '0) ? 4'd0 : word2[nib_base +: 4];

    // d1 comes from the result register, which still holds word1 at this nibble
    assign args.d1       = result_q[nib_base +: 4];
    assign args.d2       = d2_nib;
    assign args.carry_in = carry_q;

    nibble_alu u_alu (
        .args (args),
        .cmd  (cmd_q),
        .ret  (ret)
    );

    // INC finishes on the first nibble that does not carry
    assign done = last || (cmd_q == CMD_INC && !ret.carry_out);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q   <= 1'b0;
            carry_q  <= 1'b0;
            cmd_q    <= CMD_ADD;
            result_q <= '0;
        end else if (launch) begin
            busy_q   <= 1'b1;
            cmd_q    <= cmd;
            result_q <= word1;
            // borrow-free subtraction starts with carry set
            carry_q  <= (cmd == CMD_SUB);
        end else if (busy_q) begin
            result_q[nib_base +: 4] <= ret.res;
            carry_q                 <= ret.carry_out;
            if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign busy   = busy_q;
    assign carry  = carry_q;
    assign result = result_q;

endmodule

`default_nettype wire

//--- src/regmap_pkg.sv
// AXI4-Lite types with 8-bit addresses and 32-bit data; no burst, no protection or cache signals
`default_nettype none

package regmap_pkg;

    // master-driven signals
    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [7:0]  araddr;
        logic        rready;
    } axil_req_t;

    // slave-driven signals
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // register offsets, full byte address compared
    localparam logic [7:0] ADDR_WORD1  = 8'h00;
    localparam logic [7:0] ADDR_WORD2  = 8'h04;
    localparam logic [7:0] ADDR_CMD    = 8'h08;
    localparam logic [7:0] ADDR_STATUS = 8'h0C;
    localparam logic [7:0] ADDR_RESULT = 8'h10;

endpackage

`default_nettype wire

//--- src/serial_alu_top.sv
// serial ALU top; RESULT reads taken while busy show a partly updated word
`default_nettype none

module serial_alu_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  regmap_pkg::axil_req_t bus_req,
    output regmap_pkg::axil_rsp_t bus_rsp
);
    import alu_pkg::*;

    logic        start;
    alu_cmd_t    cmd;
    logic [31:0] word1;
    logic [31:0] word2;
    logic        busy;
    logic        carry;
    logic [31:0] result;

    axil_alu_regs u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .busy    (busy),
        .carry   (carry),
        .result  (result),
        .start   (start),
        .cmd     (cmd),
        .word1   (word1),
        .word2   (word2)
    );

    nibble_loop u_loop (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .cmd    (cmd),
        .word1  (word1),
        .word2  (word2),
        .busy   (busy),
        .carry  (carry),
        .result (result)
    );

endmodule

`default_nettype wire

//--- testbench/tb_bus_tasks.svh
// AXI4-Lite master tasks for one transaction at a time; inputs change 1 unit after the rising edge
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// compare a 32-bit value and stop on the first mismatch
task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        stop_with_failure($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                                    $time, name, got, exp));
    end
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, output logic [1:0] resp);
    int n;
    bus_req.awaddr  = addr;
    bus_req.wdata   = data;
    bus_req.wstrb   = strb;
    bus_req.awvalid = 1'b1;
    bus_req.wvalid  = 1'b1;
    n = 0;
    // ready seen mid-cycle means the handshake completes at the next edge
    do begin
        @(negedge clk);
        n++;
        if (n > POLL_LIMIT) stop_with_failure("write address and data were never accepted");
    end while (!bus_rsp.awready && !bus_rsp.wready);
    // address and data channels are accepted in the same cycle
    expect_equal("awready", {31'd0, bus_rsp.awready}, 32'd1);
    expect_equal("wready", {31'd0, bus_rsp.wready}, 32'd1);
    @(posedge clk);
    #1;
    bus_req.awvalid = 1'b0;
    bus_req.wvalid  = 1'b0;
    bus_req.bready  = 1'b1;
    n = 0;
    do begin
        @(negedge clk);
        n++;
        if (n > POLL_LIMIT) stop_with_failure("write response never arrived");
    end while (!bus_rsp.bvalid);
    resp = bus_rsp.bresp;
    @(posedge clk);
    #1;
    bus_req.bready = 1'b0;
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
    int n;
    bus_req.araddr  = addr;
    bus_req.arvalid = 1'b1;
    n = 0;
    do begin
        @(negedge clk);
        n++;
        if (n > POLL_LIMIT) stop_with_failure("read address was never accepted");
    end while (!bus_rsp.arready);
    @(posedge clk);
    #1;
    bus_req.arvalid = 1'b0;
    bus_req.rready  = 1'b1;
    n = 0;
    do begin
        @(negedge clk);
        n++;
        if (n > POLL_LIMIT) stop_with_failure("read data never arrived");
    end while (!bus_rsp.rvalid);
    data = bus_rsp.rdata;
    resp = bus_rsp.rresp;
    @(posedge clk);
    #1;
    bus_req.rready = 1'b0;
endtask

// returns the STATUS word in which busy was read low
task automatic poll_until_idle(output logic [31:0] status);
    logic [1:0] resp;
    int         polls;
    polls = 0;
    do begin
        polls++;
        if (polls > POLL_LIMIT) stop_with_failure("busy did not clear within the poll bound");
        read_reg(ADDR_STATUS, status, resp);
        expect_equal("rresp STATUS", {30'd0, resp}, {30'd0, RESP_OKAY});
    end while (status[0]);
endtask

`endif

//--- testbench/tb_serial_alu.sv
// directed testbench for serial_alu_top; one command in flight, random operands fixed by the seed
`default_nettype none

module tb_serial_alu;
    import alu_pkg::*;
    import regmap_pkg::*;

    localparam int PERIOD       = 20;
    localparam int POLL_LIMIT   = 64;
    // upper bound on ALU commands issued over all tests
    localparam int MAX_COMMANDS = 160;
    localparam int SEED         = 32'h3595f31e;

    logic      clk = 1'b0;
    logic      arst_n;
    axil_req_t bus_req;
    axil_rsp_t bus_rsp;

    serial_alu_top uut (
        .clk     (clk),
        .arst_n  (arst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    `include "tb_bus_tasks.svh"

    // word-level reference, independent of the nibble sequencing
    task automatic compute_expected(input alu_cmd_t cmd, input logic [31:0] w1,
                                    input logic [31:0] w2, output logic [31:0] res,
                                    output logic carry);
        logic [32:0] wide;
        case (cmd)
            CMD_ADD:   wide = {1'b0, w1} + {1'b0, w2};
            // carry set means no borrow
            CMD_SUB:   wide = {1'b0, w1} + {1'b0, ~w2} + 33'd1;
            CMD_AND:   wide = {1'b0, w1 & w2};
            CMD_OR:    wide = {1'b0, w1 | w2};
            CMD_XOR:   wide = {1'b0, w1 ^ w2};
            CMD_RSHFT: wide = {w2[0], 1'b0, w2[31:1]};
            CMD_INC:   wide = {1'b0, w1} + {29'd0, w2[3:0]};
            default:   wide = {1'b0, w1};
        endcase
        res   = wide[31:0];
        carry = wide[32];
    endtask

    task automatic start_command(input alu_cmd_t cmd, input logic [31:0] w1,
                                 input logic [31:0] w2);
        logic [1:0] resp;
        write_reg(ADDR_WORD1, w1, 4'hF, resp);
        expect_equal("bresp WORD1", {30'd0, resp}, {30'd0, RESP_OKAY});
        write_reg(ADDR_WORD2, w2, 4'hF, resp);
        expect_equal("bresp WORD2", {30'd0, resp}, {30'd0, RESP_OKAY});
        write_reg(ADDR_CMD, {29'd0, cmd}, 4'hF, resp);
        expect_equal("bresp CMD", {30'd0, resp}, {30'd0, RESP_OKAY});
    endtask

    task automatic check_completion(input logic [31:0] exp_res, input logic exp_carry);
        logic [31:0] data;
        logic [1:0]  resp;
        poll_until_idle(data);
        expect_equal("STATUS", data, {30'd0, exp_carry, 1'b0});
        read_reg(ADDR_RESULT, data, resp);
        expect_equal("rresp RESULT", {30'd0, resp}, {30'd0, RESP_OKAY});
        expect_equal("RESULT", data, exp_res);
    endtask

    task automatic run_command(input alu_cmd_t cmd, input logic [31:0] w1, input logic [31:0] w2);
        logic [31:0] exp_res;
        logic        exp_carry;
        compute_expected(cmd, w1, w2, exp_res, exp_carry);
        start_command(cmd, w1, w2);
        check_completion(exp_res, exp_carry);
    endtask

    task automatic reset_and_strobes();
        logic [31:0] data;
        logic [1:0]  resp;
        read_reg(ADDR_STATUS, data, resp);
        expect_equal("STATUS after reset", data, 32'd0);
        read_reg(ADDR_RESULT, data, resp);
        expect_equal("RESULT after reset", data, 32'd0);
        write_reg(ADDR_WORD1, 32'h12345678, 4'hF, resp);
        read_reg(ADDR_WORD1, data, resp);
        expect_equal("WORD1", data, 32'h12345678);
        write_reg(ADDR_WORD1, 32'hAABBCCDD, 4'b0101, resp);
        read_reg(ADDR_WORD1, data, resp);
        expect_equal("WORD1 masked", data, 32'h12BB56DD);
        write_reg(ADDR_WORD2, 32'h9ABCDEF0, 4'hF, resp);
        write_reg(ADDR_WORD2, 32'h11223344, 4'b1010, resp);
        read_reg(ADDR_WORD2, data, resp);
        expect_equal("WORD2 masked", data, 32'h11BC33F0);
    endtask

    task automatic arithmetic_and_logic();
        alu_cmd_t ops[5];
        ops = '{CMD_ADD, CMD_SUB, CMD_AND, CMD_OR, CMD_XOR};
        foreach (ops[i]) begin
            // carry ripples through seven nibbles, a zero nibble stops it, a borrow wraps
            run_command(ops[i], 32'hEFFFFFFF, 32'h1);
            run_command(ops[i], 32'hFFFF0FFF, 32'h2);
            run_command(ops[i], 32'h0, 32'h1);
            repeat (20) run_command(ops[i], $urandom, $urandom);
        end
    endtask

    task automatic shift_right_cases();
        run_command(CMD_RSHFT, $urandom, 32'h06000000);
        repeat (8) run_command(CMD_RSHFT, $urandom, $urandom);
    endtask

    task automatic increment_cases();
        logic [3:0] nib[3];
        nib = '{4'd0, 4'd1, 4'd15};
        foreach (nib[i]) begin
            // upper bits of word2 must not reach the sum
            run_command(CMD_INC, $urandom, {28'($urandom), nib[i]});
            run_command(CMD_INC, 32'hFFFFFFFF, {28'($urandom), nib[i]});
            run_command(CMD_INC, 32'h0FFFFFFF, {28'($urandom), nib[i]});
        end
    endtask

    task automatic command_while_busy();
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] exp_res;
        logic        exp_carry;
        logic [1:0]  resp;
        w1 = $urandom;
        w2 = $urandom;
        compute_expected(CMD_ADD, w1, w2, exp_res, exp_carry);
        start_command(CMD_ADD, w1, w2);
        write_reg(ADDR_CMD, {29'd0, CMD_XOR}, 4'hF, resp);
        expect_equal("bresp CMD while busy", {30'd0, resp}, {30'd0, RESP_SLVERR});
        check_completion(exp_res, exp_carry);
    endtask

    task automatic illegal_accesses();
        logic [31:0] data;
        logic [1:0]  resp;
        write_reg(8'h14, 32'hFFFFFFFF, 4'hF, resp);
        expect_equal("bresp 0x14", {30'd0, resp}, {30'd0, RESP_SLVERR});
        read_reg(8'h14, data, resp);
        expect_equal("rresp 0x14", {30'd0, resp}, {30'd0, RESP_SLVERR});
        expect_equal("rdata 0x14", data, 32'd0);
        write_reg(ADDR_STATUS, 32'h3, 4'hF, resp);
        expect_equal("bresp STATUS", {30'd0, resp}, {30'd0, RESP_SLVERR});
        write_reg(ADDR_RESULT, 32'h1, 4'hF, resp);
        expect_equal("bresp RESULT", {30'd0, resp}, {30'd0, RESP_SLVERR});
    endtask

    initial begin
        bus_req = '0;
        arst_n  = 1'b0;
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        reset_and_strobes();
        arithmetic_and_logic();
        shift_right_cases();
        increment_cases();
        command_while_busy();
        illegal_accesses();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        #(MAX_COMMANDS * POLL_LIMIT * PERIOD);
        stop_with_failure("watchdog expired before the tests completed");
    end

endmodule

`default_nettype wire
